// File: verilog/frame_pkg.sv
// Board layer shared types: host words, download and programming ports, DB15 reader
`default_nettype none

package frame_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Host side words

    typedef logic [31:0] status_t;
    typedef logic [ 9:0] joy_t;
    typedef logic [ 6:0] user_port_t;

    // Bit positions inside the host words
    localparam int STATUS_RST_BIT  = 0;
    localparam int STATUS_SNAC_LSB = 30;
    localparam int BUTTON_RST_BIT  = 1;

    ////////////////////////////////////////////////////////////////////////////
    // ROM download and SDRAM programming

    typedef logic [21:0] prog_addr_t;
    typedef logic [22:0] ioctl_addr_t;

    typedef struct packed {
        logic        wr;
        ioctl_addr_t addr;
        logic [7:0]  data;
    } ioctl_s;

    // Mask is active low, one byte lane cleared per write
    typedef struct packed {
        logic       we;
        prog_addr_t addr;
        logic [7:0] data;
        logic [1:0] mask;
    } prog_s;

    ////////////////////////////////////////////////////////////////////////////
    // PLL and DB15 adapter

    localparam int PLL_RST_CYCLES = 256;
    localparam int JOY_FRAME_BITS = 20;

    // User port lanes used by the serial adapter
    localparam int JOY_LOAD_BIT = 0;
    localparam int JOY_CLK_BIT  = 1;
    localparam int JOY_DATA_BIT = 5;

    typedef enum logic [1:0] {
        SNAC_OFF = 2'd0,
        SNAC_ONE = 2'd1,
        SNAC_TWO = 2'd2
    } snac_mode_e;

    typedef enum logic [1:0] {
        JS_IDLE,
        JS_LOAD,
        JS_SHIFT,
        JS_UPDATE
    } joy_state_e;

endpackage

`default_nettype wire

// File: verilog/pll_reset_ctrl.sv
// PLL watchdog that turns a loss of lock into a fixed-length PLL reset pulse
`timescale 1ns/100ps
`default_nettype none

module pll_reset_ctrl (
    input  logic clk_sys,
    input  logic RESET,
    input  logic pll_locked,
    output logic pll_rst
);

    localparam int CW = $clog2(frame_pkg::PLL_RST_CYCLES);

    logic          last_locked;
    logic [CW-1:0] rst_cnt;
    logic          lock_drop;

    // Falling edge of lock, seen against last cycle's sample
    assign lock_drop = last_locked && !pll_locked;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
            rst_cnt     <= '0;
            pll_rst     <= 1'b0;
        end else begin
            last_locked <= pll_locked;
            if (lock_drop) begin
                // Restart the full pulse, also when one is already running
                rst_cnt <= CW'(frame_pkg::PLL_RST_CYCLES - 1);
                pll_rst <= 1'b1;
            end else if (rst_cnt != '0) begin
                rst_cnt <= rst_cnt - 1'b1;
            end else begin
                pll_rst <= 1'b0;
            end
        end
    end

    // Pulse covers the loading edge plus one edge per count step,
    // so the PLL sees PLL_RST_CYCLES cycles of reset in total.
    // A clock that wanders off lock is pulled back this way without
    // touching the board reset or the game.

endmodule

`default_nettype wire

// File: verilog/board_reset.sv
// Board and game reset sequencing from reset requests and the ROM download state
`timescale 1ns/100ps
`default_nettype none

module board_reset #(
    parameter int RST_HOLD = 16
) (
    input  logic clk_sys,
    input  logic RESET,
    input  logic status_rst,
    input  logic button_rst,
    input  logic downloading,
    output logic rst,
    output logic game_rst
);

    localparam int CW = $clog2(RST_HOLD + 1);

    // Index 0 builds rst, index 1 builds game_rst
    logic [1:0]    req;
    logic [CW-1:0] hold_cnt [2];

    assign req[0] = RESET | status_rst | button_rst;
    assign req[1] = rst | downloading;

    ////////////////////////////////////////////////////////////////////////////
    // Hold-off counters

    // Reloaded while the request is high, run down once it is gone
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            for (int i = 0; i < 2; i++) begin
                hold_cnt[i] <= CW'(RST_HOLD);
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (req[i]) begin
                    hold_cnt[i] <= CW'(RST_HOLD);
                end else if (hold_cnt[i] != '0) begin
                    hold_cnt[i] <= hold_cnt[i] - 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reset levels

    // Request shows up at once, release waits RST_HOLD edges
    assign rst = req[0] | (hold_cnt[0] != '0);

    // Game stays held through a download and restarts only on a loaded ROM
    assign game_rst = req[1] | (hold_cnt[1] != '0);

endmodule

`default_nettype wire

// File: verilog/rom_loader.sv
// ROM loader turning byte download writes into masked 16-bit programming writes
`timescale 1ns/100ps
`default_nettype none

module rom_loader (
    input  logic              clk_sys,
    input  logic              RESET,
    input  frame_pkg::ioctl_s ioctl,
    input  logic              downloading,
    output frame_pkg::prog_s  prog,
    output logic              dwnld_busy
);

    logic                  we_q;
    frame_pkg::prog_addr_t addr_q;
    logic [7:0]            data_q;
    logic [1:0]            mask_q;

    ////////////////////////////////////////////////////////////////////////////
    // Write strobe

    // One programming strobe per download strobe, one edge later
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            we_q <= 1'b0;
        end else begin
            we_q <= ioctl.wr;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Write payload

    always_ff @(posedge clk_sys) begin
        if (ioctl.wr) begin
            // Word address is the byte address without its lane bit
            addr_q <= ioctl.addr[22:1];
            data_q <= ioctl.data;
            // Even byte goes to the low lane, odd byte to the high lane
            if (ioctl.addr[0]) begin
                mask_q <= 2'b01;
            end else begin
                mask_q <= 2'b10;
            end
        end
    end

    assign prog = '{
        we:   we_q,
        addr: addr_q,
        data: data_q,
        mask: mask_q
    };

    // Busy until the download ends and the last write has gone out
    assign dwnld_busy = downloading | we_q;

    // No queue is needed here. The host sends at most one byte per
    // cycle and each one leaves on the very next edge.

endmodule

`default_nettype wire

// File: verilog/db15_joy_reader.sv
// Serial DB15 joystick adapter reader on the user port, merged with host joysticks
`timescale 1ns/100ps
`default_nettype none

module db15_joy_reader #(
    parameter int JOY_DIV = 4
) (
    input  logic                  clk_sys,
    input  logic                  RESET,
    input  frame_pkg::snac_mode_e snac_mode,
    input  frame_pkg::user_port_t user_in,
    input  frame_pkg::joy_t       hps_joy1,
    input  frame_pkg::joy_t       hps_joy2,
    output frame_pkg::joy_t       game_joy1,
    output frame_pkg::joy_t       game_joy2,
    output frame_pkg::user_port_t user_out,
    output logic                  user_mode
);

    localparam int NB = frame_pkg::JOY_FRAME_BITS;
    localparam int JW = $bits(frame_pkg::joy_t);
    localparam int DW = (JOY_DIV > 1) ? $clog2(JOY_DIV) : 1;
    localparam int BW = $clog2(NB + 1);

    frame_pkg::joy_state_e state;
    logic [DW-1:0]         div_cnt;
    logic [BW-1:0]         bit_cnt;
    logic                  load_q;
    logic                  clk_q;
    logic [NB-1:0]         shift_q;
    frame_pkg::joy_t       p1_q;
    frame_pkg::joy_t       p2_q;
    logic                  snac_on;
    logic                  phase_end;
    logic                  clk_rise;
    logic                  joy_bit;

    assign snac_on   = snac_mode != frame_pkg::SNAC_OFF;
    // Adapter data is active low
    assign joy_bit   = ~user_in[frame_pkg::JOY_DATA_BIT];
    assign phase_end = div_cnt == DW'(JOY_DIV - 1);
    // JOY_CLK goes high at the end of the load phase or of a low phase
    assign clk_rise  = phase_end && ((state == frame_pkg::JS_LOAD) ||
                       (state == frame_pkg::JS_SHIFT && !clk_q));

    ////////////////////////////////////////////////////////////////////////////
    // Frame FSM

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            state   <= frame_pkg::JS_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            load_q  <= 1'b0;
            clk_q   <= 1'b0;
            p1_q    <= '0;
            p2_q    <= '0;
        end else if (!snac_on) begin
            state   <= frame_pkg::JS_IDLE;
            div_cnt <= '0;
            load_q  <= 1'b0;
            clk_q   <= 1'b0;
        end else begin
            if (state == frame_pkg::JS_IDLE || phase_end) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            case (state)
                frame_pkg::JS_IDLE: begin
                    state   <= frame_pkg::JS_LOAD;
                    load_q  <= 1'b1;
                    bit_cnt <= '0;
                end
                frame_pkg::JS_LOAD, frame_pkg::JS_SHIFT: begin
                    if (clk_rise) begin
                        load_q  <= 1'b0;
                        clk_q   <= 1'b1;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BW'(NB - 1)) begin
                            state <= frame_pkg::JS_UPDATE;
                        end else begin
                            state <= frame_pkg::JS_SHIFT;
                        end
                    end else if (phase_end && clk_q) begin
                        // Falling edge, adapter moves on to its next bit
                        clk_q <= 1'b0;
                    end
                end
                frame_pkg::JS_UPDATE: begin
                    // First cycle after the last sample
                    if (clk_q && div_cnt == '0) begin
                        p1_q <= shift_q[NB-1 -: JW];
                        p2_q <= shift_q[JW-1:0];
                    end
                    // Finish the last pulse, then start the next frame
                    if (phase_end) begin
                        if (clk_q) begin
                            clk_q <= 1'b0;
                        end else begin
                            state   <= frame_pkg::JS_LOAD;
                            load_q  <= 1'b1;
                            bit_cnt <= '0;
                        end
                    end
                end
                default: state <= frame_pkg::JS_IDLE;
            endcase
        end
    end

    // Player 1 arrives first, MSB first
    always_ff @(posedge clk_sys) begin
        if (clk_rise) begin
            shift_q <= {shift_q[NB-2:0], joy_bit};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs

    // Released port reads all ones on the open-drain lines
    always_comb begin
        user_out = '1;
        if (snac_on) begin
            user_out[frame_pkg::JOY_LOAD_BIT] = load_q;
            user_out[frame_pkg::JOY_CLK_BIT]  = clk_q;
        end
    end

    assign user_mode = snac_on;
    assign game_joy1 = hps_joy1 | (snac_on ? p1_q : '0);
    assign game_joy2 = hps_joy2 | ((snac_mode == frame_pkg::SNAC_TWO) ? p2_q : '0);

endmodule

`default_nettype wire

// File: verilog/frame_core.sv
// Board-support layer top: PLL watchdog, reset sequencing, ROM loader, DB15 reader
`timescale 1ns/100ps
`default_nettype none

module frame_core #(
    parameter int RST_HOLD = 16,
    parameter int JOY_DIV  = 4
) (
    input  logic                  clk_sys,
    input  logic                  RESET,
    input  logic                  pll_locked,
    input  frame_pkg::status_t    status,
    input  logic [1:0]            buttons,
    input  frame_pkg::ioctl_s     ioctl,
    input  logic                  ioctl_download,
    input  frame_pkg::joy_t       hps_joy1,
    input  frame_pkg::joy_t       hps_joy2,
    input  frame_pkg::user_port_t user_in,
    output logic                  pll_rst,
    output logic                  rst,
    output logic                  game_rst,
    output frame_pkg::prog_s      prog,
    output logic                  dwnld_busy,
    output frame_pkg::joy_t       game_joy1,
    output frame_pkg::joy_t       game_joy2,
    output frame_pkg::user_port_t user_out,
    output logic                  user_mode
);

    frame_pkg::snac_mode_e snac_mode;

    // OSD option for the DB15 adapter, code 3 is unused and leaves it off
    always_comb begin
        case (status[frame_pkg::STATUS_SNAC_LSB +: 2])
            2'd1:    snac_mode = frame_pkg::SNAC_ONE;
            2'd2:    snac_mode = frame_pkg::SNAC_TWO;
            default: snac_mode = frame_pkg::SNAC_OFF;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Clock and reset

    pll_reset_ctrl u_pll_rst (
        .clk_sys    ( clk_sys    ),
        .RESET      ( RESET      ),
        .pll_locked ( pll_locked ),
        .pll_rst    ( pll_rst    )
    );

    board_reset #(
        .RST_HOLD ( RST_HOLD )
    ) u_reset (
        .clk_sys     ( clk_sys                            ),
        .RESET       ( RESET                              ),
        .status_rst  ( status[frame_pkg::STATUS_RST_BIT]  ),
        .button_rst  ( buttons[frame_pkg::BUTTON_RST_BIT] ),
        .downloading ( ioctl_download                     ),
        .rst         ( rst                                ),
        .game_rst    ( game_rst                           )
    );

    ////////////////////////////////////////////////////////////////////////////
    // ROM download

    rom_loader u_loader (
        .clk_sys     ( clk_sys        ),
        .RESET       ( RESET          ),
        .ioctl       ( ioctl          ),
        .downloading ( ioctl_download ),
        .prog        ( prog           ),
        .dwnld_busy  ( dwnld_busy     )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Joysticks

    db15_joy_reader #(
        .JOY_DIV ( JOY_DIV )
    ) u_joy (
        .clk_sys   ( clk_sys   ),
        .RESET     ( RESET     ),
        .snac_mode ( snac_mode ),
        .user_in   ( user_in   ),
        .hps_joy1  ( hps_joy1  ),
        .hps_joy2  ( hps_joy2  ),
        .game_joy1 ( game_joy1 ),
        .game_joy2 ( game_joy2 ),
        .user_out  ( user_out  ),
        .user_mode ( user_mode )
    );

endmodule

`default_nettype wire

// File: test/frame_assertions.sv
// Protocol assertions on the board layer top, bound into every frame_core
`timescale 1ns/100ps
`default_nettype none

module frame_assertions (
    input logic                  clk_sys,
    input logic                  RESET,
    input logic                  pll_locked,
    input logic                  pll_rst,
    input frame_pkg::ioctl_s     ioctl,
    input frame_pkg::prog_s      prog,
    input frame_pkg::user_port_t user_out,
    input logic                  user_mode
);

    int fail_count = 0;

    // Each programming strobe comes from one download strobe an edge earlier
    a_we_from_wr: assert property (@(posedge clk_sys) disable iff (RESET)
        prog.we |-> $past(ioctl.wr))
        else begin
            $error("prog.we high without a download write on the previous cycle");
            fail_count++;
        end

    // A PLL reset pulse starts only on a high-to-low step of lock
    a_pll_rst_cause: assert property (@(posedge clk_sys) disable iff (RESET)
        $rose(pll_rst) |-> $past(!pll_locked) && $past(pll_locked, 2))
        else begin
            $error("pll_rst rose without a drop of pll_locked");
            fail_count++;
        end

    // Load and shift clock of the adapter never overlap
    a_load_clk_apart: assert property (@(posedge clk_sys) disable iff (RESET)
        user_mode |-> !(user_out[frame_pkg::JOY_LOAD_BIT] && user_out[frame_pkg::JOY_CLK_BIT]))
        else begin
            $error("JOY_LOAD and JOY_CLK high at the same time");
            fail_count++;
        end

endmodule

bind frame_core frame_assertions u_assert (
    .clk_sys    ( clk_sys    ),
    .RESET      ( RESET      ),
    .pll_locked ( pll_locked ),
    .pll_rst    ( pll_rst    ),
    .ioctl      ( ioctl      ),
    .prog       ( prog       ),
    .user_out   ( user_out   ),
    .user_mode  ( user_mode  )
);

`default_nettype wire

// File: test/frame_checker.sv
// Reference model and scoreboard for the board layer outputs
`timescale 1ns/100ps
`default_nettype none

module frame_checker #(
    parameter int RST_HOLD = 16,
    parameter int JOY_DIV  = 4
) (
    input  logic                  clk_sys,
    input  logic                  RESET,
    input  logic                  pll_locked,
    input  frame_pkg::status_t    status,
    input  logic [1:0]            buttons,
    input  frame_pkg::ioctl_s     ioctl,
    input  logic                  ioctl_download,
    input  frame_pkg::joy_t       hps_joy1,
    input  frame_pkg::joy_t       hps_joy2,
    input  logic [19:0]           dev_frame,
    input  logic [2:0]            test_id,
    input  logic                  pll_rst,
    input  logic                  rst,
    input  logic                  game_rst,
    input  frame_pkg::prog_s      prog,
    input  logic                  dwnld_busy,
    input  frame_pkg::joy_t       game_joy1,
    input  frame_pkg::joy_t       game_joy2,
    input  frame_pkg::user_port_t user_out,
    input  logic                  user_mode,
    output int                    error_count
);

    // Frame: load phase, then one high and one low phase per bit
    localparam int FRAME_LEN = JOY_DIV + 2 * JOY_DIV * frame_pkg::JOY_FRAME_BITS;
    localparam int LAST_RISE = FRAME_LEN - 2 * JOY_DIV;

    logic        m_last_lock;
    int          m_pll_cnt;
    int          m_hold [2];
    logic        m_we;
    logic [21:0] m_addr;
    logic [7:0]  m_data;
    logic [1:0]  m_mask;
    logic        m_run;
    int          m_t;
    logic [9:0]  m_p1;
    logic [9:0]  m_p2;
    logic [2:0]  cur_test = '0;
    int          test_errs = 0;

    initial error_count = 0;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1:    return "PLL lock loss";
            3'd2:    return "reset sequencing";
            3'd3:    return "ROM download";
            3'd4:    return "DB15 two players";
            default: return "DB15 modes";
        endcase
    endfunction

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, exp);
            error_count++;
            test_errs++;
        end
    endtask

    always @(test_id) begin
        if (cur_test != '0) begin
            $display("Test %0d (%s) done, %0d errors", cur_test, test_name(cur_test), test_errs);
        end
        cur_test  = test_id;
        test_errs = 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Model, stepped on each clock edge

    always @(posedge clk_sys or posedge RESET) begin
        logic req;
        logic rst_pre;
        if (RESET) begin
            m_last_lock = 1'b0;
            m_pll_cnt   = 0;
            m_hold[0]   = RST_HOLD;
            m_hold[1]   = RST_HOLD;
            m_we        = 1'b0;
            m_run       = 1'b0;
            m_t         = 0;
            m_p1        = '0;
            m_p2        = '0;
        end else begin
            if (m_last_lock && !pll_locked) begin
                m_pll_cnt = frame_pkg::PLL_RST_CYCLES;
            end else if (m_pll_cnt > 0) begin
                m_pll_cnt--;
            end
            m_last_lock = pll_locked;

            // Game hold-off sees rst as it was before this edge
            req     = status[0] | buttons[1];
            rst_pre = req | (m_hold[0] != 0);
            if (rst_pre | ioctl_download) begin
                m_hold[1] = RST_HOLD;
            end else if (m_hold[1] > 0) begin
                m_hold[1]--;
            end
            if (req) begin
                m_hold[0] = RST_HOLD;
            end else if (m_hold[0] > 0) begin
                m_hold[0]--;
            end

            m_we = ioctl.wr;
            if (ioctl.wr) begin
                m_addr = ioctl.addr >> 1;
                m_data = ioctl.data;
                m_mask = ioctl.addr[0] ? 2'b01 : 2'b10;
            end

            if (status[31:30] != 2'd1 && status[31:30] != 2'd2) begin
                m_run = 1'b0;
            end else if (!m_run) begin
                m_run = 1'b1;
                m_t   = 0;
            end else begin
                m_t = (m_t + 1) % FRAME_LEN;
                // Player 1 came first, MSB first
                if (m_t == LAST_RISE + 1) begin
                    m_p1 = dev_frame[19:10];
                    m_p2 = dev_frame[9:0];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Comparison, mid-cycle where everything has settled

    always @(negedge clk_sys) begin
        logic on;
        logic exp_rst;
        logic exp_load;
        logic exp_clk;
        if (test_id != '0) begin
            on      = (status[31:30] == 2'd1) || (status[31:30] == 2'd2);
            exp_rst = RESET | status[0] | buttons[1] | (m_hold[0] != 0);
            compare("pll_rst", pll_rst, m_pll_cnt > 0);
            compare("rst", rst, exp_rst);
            compare("game_rst", game_rst, exp_rst | ioctl_download | (m_hold[1] != 0));
            compare("prog.we", prog.we, m_we);
            if (m_we) begin
                compare("prog.addr", prog.addr, m_addr);
                compare("prog.data", prog.data, m_data);
                compare("prog.mask", prog.mask, m_mask);
            end
            compare("dwnld_busy", dwnld_busy, ioctl_download | m_we);
            exp_load = m_run && (m_t < JOY_DIV);
            exp_clk  = m_run && (m_t >= JOY_DIV) && ((m_t - JOY_DIV) % (2 * JOY_DIV) < JOY_DIV);
            if (on) begin
                compare("user_mode", user_mode, 1'b1);
                compare("user_out[6:2]", user_out[6:2], 5'h1f);
                compare("JOY_LOAD", user_out[0], exp_load);
                compare("JOY_CLK", user_out[1], exp_clk);
            end else begin
                compare("user_mode", user_mode, 1'b0);
                compare("user_out", user_out, 7'h7f);
            end
            compare("game_joy1", game_joy1, hps_joy1 | (on ? m_p1 : 10'h0));
            compare("game_joy2", game_joy2,
                    hps_joy2 | ((status[31:30] == 2'd2) ? m_p2 : 10'h0));
        end
    end

endmodule

`default_nettype wire

// File: test/frame_core_tb.sv
// Testbench for the board layer: stimulus, DB15 adapter model, watchdog and summary
`timescale 1ns/100ps
`default_nettype none

module frame_core_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RST_HOLD     = 16;
    localparam int JOY_DIV      = 4;
    localparam int FRAME_CYCLES = JOY_DIV + 2 * JOY_DIV * frame_pkg::JOY_FRAME_BITS;

    // Worst-case length of each test in clock cycles
    localparam int PLL_CYCLES   = 6 * 403 + 300;
    localparam int RESET_CYCLES = 24 * 8 + 6 * (RST_HOLD + 8) + 2 * RST_HOLD + 8;
    localparam int LOAD_CYCLES  = 200 * 3 + RST_HOLD + 8;
    localparam int TWO_CYCLES   = 8 * FRAME_CYCLES;
    localparam int MODE_CYCLES  = 8 * FRAME_CYCLES + 200;
    localparam int TOTAL_CYCLES = RST_HOLD + 8 + PLL_CYCLES + RESET_CYCLES + LOAD_CYCLES +
                                  TWO_CYCLES + MODE_CYCLES;
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_PERIOD * 12 / 10;

    logic                  clk_sys;
    logic                  RESET;
    logic                  pll_locked;
    frame_pkg::status_t    status;
    logic [1:0]            buttons;
    frame_pkg::ioctl_s     ioctl;
    logic                  ioctl_download;
    frame_pkg::joy_t       hps_joy1;
    frame_pkg::joy_t       hps_joy2;
    frame_pkg::user_port_t user_in;
    logic                  pll_rst;
    logic                  rst;
    logic                  game_rst;
    frame_pkg::prog_s      prog;
    logic                  dwnld_busy;
    frame_pkg::joy_t       game_joy1;
    frame_pkg::joy_t       game_joy2;
    frame_pkg::user_port_t user_out;
    logic                  user_mode;

    logic [2:0]  test_id;
    int          seed;
    int          dev_seed;
    logic [19:0] dev_frame;
    logic [19:0] dev_shift;
    logic        load_seen;
    logic        clk_seen;

    frame_core #(
        .RST_HOLD ( RST_HOLD ),
        .JOY_DIV  ( JOY_DIV  )
    ) u_dut (
        .clk_sys        ( clk_sys        ),
        .RESET          ( RESET          ),
        .pll_locked     ( pll_locked     ),
        .status         ( status         ),
        .buttons        ( buttons        ),
        .ioctl          ( ioctl          ),
        .ioctl_download ( ioctl_download ),
        .hps_joy1       ( hps_joy1       ),
        .hps_joy2       ( hps_joy2       ),
        .user_in        ( user_in        ),
        .pll_rst        ( pll_rst        ),
        .rst            ( rst            ),
        .game_rst       ( game_rst       ),
        .prog           ( prog           ),
        .dwnld_busy     ( dwnld_busy     ),
        .game_joy1      ( game_joy1      ),
        .game_joy2      ( game_joy2      ),
        .user_out       ( user_out       ),
        .user_mode      ( user_mode      )
    );

    frame_checker #(
        .RST_HOLD ( RST_HOLD ),
        .JOY_DIV  ( JOY_DIV  )
    ) u_check (
        .clk_sys        ( clk_sys        ),
        .RESET          ( RESET          ),
        .pll_locked     ( pll_locked     ),
        .status         ( status         ),
        .buttons        ( buttons        ),
        .ioctl          ( ioctl          ),
        .ioctl_download ( ioctl_download ),
        .hps_joy1       ( hps_joy1       ),
        .hps_joy2       ( hps_joy2       ),
        .dev_frame      ( dev_frame      ),
        .test_id        ( test_id        ),
        .pll_rst        ( pll_rst        ),
        .rst            ( rst            ),
        .game_rst       ( game_rst       ),
        .prog           ( prog           ),
        .dwnld_busy     ( dwnld_busy     ),
        .game_joy1      ( game_joy1      ),
        .game_joy2      ( game_joy2      ),
        .user_out       ( user_out       ),
        .user_mode      ( user_mode      ),
        .error_count    (                )
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    ////////////////////////////////////////////////////////////////////////////
    // DB15 adapter model

    // Data line is active low and idles high
    assign user_in = {1'b1, ~dev_shift[19], 5'b1_1111};

    // Parallel load while JOY_LOAD is high, next bit after each JOY_CLK fall
    always @(posedge clk_sys) begin
        #10;
        if (!user_mode) begin
            load_seen = 1'b0;
            clk_seen  = 1'b0;
        end else begin
            if (user_out[frame_pkg::JOY_LOAD_BIT]) begin
                if (!load_seen) begin
                    dev_frame = 20'($random(dev_seed));
                end
                dev_shift = dev_frame;
            end else if (clk_seen && !user_out[frame_pkg::JOY_CLK_BIT]) begin
                dev_shift = {dev_shift[18:0], 1'b0};
            end
            load_seen = user_out[frame_pkg::JOY_LOAD_BIT];
            clk_seen  = user_out[frame_pkg::JOY_CLK_BIT];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers and tests

    task automatic tick();
        @(posedge clk_sys);
        #10;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Returns at the start of the n-th JOY_LOAD pulse
    task automatic wait_frames(input int n);
        int   seen;
        logic prev;
        seen = 0;
        prev = user_out[frame_pkg::JOY_LOAD_BIT];
        while (seen < n) begin
            tick();
            if (user_out[frame_pkg::JOY_LOAD_BIT] && !prev) begin
                seen++;
            end
            prev = user_out[frame_pkg::JOY_LOAD_BIT];
        end
    endtask

    task automatic pll_drop_test();
        int gap;
        for (int i = 0; i < 6; i++) begin
            // Odd rounds drop again while the pulse is still running
            if (i % 2 == 1) begin
                gap = 40 + rand_below(150);
            end else begin
                gap = 300 + rand_below(100);
            end
            idle(gap);
            pll_locked = 1'b0;
            idle(1 + rand_below(3));
            pll_locked = 1'b1;
        end
        idle(300);
    endtask

    task automatic reset_request_test();
        logic [8:0] r;
        for (int i = 0; i < 24; i++) begin
            r = 9'($random(seed));
            RESET          = (r[5:3] == 3'd0);
            status[0]      = r[0];
            buttons[1]     = r[1];
            ioctl_download = r[2];
            idle(1 + r[8:6]);
            if (i % 4 == 3) begin
                RESET          = 1'b0;
                status[0]      = 1'b0;
                buttons[1]     = 1'b0;
                ioctl_download = 1'b0;
                idle(RST_HOLD + 8);
            end
        end
        idle(2 * RST_HOLD + 8);
    endtask

    task automatic download_test();
        ioctl_download = 1'b1;
        idle(2);
        for (int i = 0; i < 200; i++) begin
            ioctl.wr   = 1'b1;
            ioctl.addr = frame_pkg::ioctl_addr_t'($random(seed));
            ioctl.data = 8'($random(seed));
            tick();
            ioctl.wr = 1'b0;
            idle(rand_below(3));
        end
        // Download may end while the last write is still pending
        ioctl_download = 1'b0;
        idle(RST_HOLD + 8);
    endtask

    task automatic two_player_test();
        status[31:30] = 2'd2;
        for (int i = 0; i < 7; i++) begin
            hps_joy1 = 10'($random(seed) & $random(seed));
            hps_joy2 = 10'($random(seed) & $random(seed));
            wait_frames(1);
        end
    endtask

    task automatic mode_test();
        status[31:30] = 2'd1;
        for (int i = 0; i < 4; i++) begin
            hps_joy1 = 10'($random(seed) & $random(seed));
            hps_joy2 = 10'($random(seed) & $random(seed));
            wait_frames(1);
        end
        status[31:30] = 2'd0;
        for (int i = 0; i < 5; i++) begin
            hps_joy1 = 10'($random(seed));
            hps_joy2 = 10'($random(seed));
            idle(10);
        end
        status[31:30] = 2'd2;
        wait_frames(2);
        // Switch players mid-frame, then drop the adapter
        status[31:30] = 2'd1;
        idle(80);
        status[31:30] = 2'd0;
        idle(20);
    endtask

    initial begin
        int ck_errs;
        int as_errs;
        seed           = 21;
        dev_seed       = 21;
        test_id        = '0;
        RESET          = 1'b1;
        pll_locked     = 1'b1;
        status         = '0;
        buttons        = '0;
        ioctl          = '0;
        ioctl_download = 1'b0;
        hps_joy1       = '0;
        hps_joy2       = '0;
        dev_frame      = '0;
        dev_shift      = '0;
        load_seen      = 1'b0;
        clk_seen       = 1'b0;
        repeat (3) @(posedge clk_sys);
        #10;
        RESET = 1'b0;
        idle(RST_HOLD + 4);

        test_id = 3'd1;
        pll_drop_test();
        test_id = 3'd2;
        reset_request_test();
        test_id = 3'd3;
        download_test();
        test_id = 3'd4;
        two_player_test();
        test_id = 3'd5;
        mode_test();
        test_id = '0;
        idle(2);

        ck_errs = u_check.error_count;
        as_errs = u_dut.u_assert.fail_count;
        $display("Summary: %0d checker errors, %0d assertion failures", ck_errs, as_errs);
        if (ck_errs + as_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
verilog/frame_pkg.sv
verilog/pll_reset_ctrl.sv
verilog/board_reset.sv
verilog/rom_loader.sv
verilog/db15_joy_reader.sv
verilog/frame_core.sv
test/frame_assertions.sv
test/frame_checker.sv
test/frame_core_tb.sv

// File: Bender.yml
package:
  name: frame_core

sources:
  - verilog/frame_pkg.sv
  - verilog/pll_reset_ctrl.sv
  - verilog/board_reset.sv
  - verilog/rom_loader.sv
  - verilog/db15_joy_reader.sv
  - verilog/frame_core.sv
  - target: test
    files:
      - test/frame_assertions.sv
      - test/frame_checker.sv
      - test/frame_core_tb.sv
